// File: wavegen_pkg.sv
// Widths, types, register map and buffer sizing shared by the square-wave generator blocks
package wavegen_pkg;

    // Width of the phase counter and of every timing setting
    localparam int COUNTER_WIDTH = 32;

    // Number of samples the output sender can hold
    localparam int FIFO_DEPTH = 4;
    // Pointer and occupancy widths for the sender buffer
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Output levels and configuration write data
    typedef logic [31:0] word_t;
    // Phase counter, start delay, on time and period
    typedef logic [COUNTER_WIDTH-1:0] phase_t;
    // Destination and user tags carried with each sample
    typedef logic [7:0] tag_t;
    // Tick divider setting
    typedef logic [15:0] div_t;
    typedef logic [3:0] cfg_addr_t;
    // Count of triggers refused because the buffer was full
    typedef logic [15:0] ovf_t;

    // Configuration register map
    localparam cfg_addr_t ADDR_V_ON = 4'd0;
    localparam cfg_addr_t ADDR_V_OFF = 4'd1;
    localparam cfg_addr_t ADDR_T_DELAY = 4'd2;
    localparam cfg_addr_t ADDR_T_ON = 4'd3;
    localparam cfg_addr_t ADDR_PERIOD = 4'd4;
    localparam cfg_addr_t ADDR_DEST = 4'd5;
    localparam cfg_addr_t ADDR_USER = 4'd6;
    localparam cfg_addr_t ADDR_TICK_DIV = 4'd7;
    // Bit 0 of the control word is the run bit
    localparam cfg_addr_t ADDR_CONTROL = 4'd8;

    // Configuration port handshake states
    typedef enum logic {
        HS_IDLE,
        HS_ACKED
    } handshake_state_e;

    // Output port handshake states
    typedef enum logic [1:0] {
        SND_IDLE,
        SND_WAIT_ACK_HIGH,
        SND_WAIT_ACK_LOW
    } sender_state_e;

endpackage

// File: param_bank.sv
// Settings register bank written through a four-phase req/ack configuration port
`timescale 1ns/100ps

module param_bank import wavegen_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      cfg_req,
    input  cfg_addr_t cfg_addr,
    input  word_t     cfg_data,
    output logic      cfg_ack,
    output word_t     v_on,
    output word_t     v_off,
    output phase_t    t_delay,
    output phase_t    t_on,
    output phase_t    period,
    output tag_t      dest,
    output tag_t      user,
    output div_t      tick_div,
    output logic      run
);

    handshake_state_e state;

    // The acknowledge is high for exactly as long as the bank sits in the acked state
    assign cfg_ack = (state == HS_ACKED);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= HS_IDLE;
            v_on <= '0;
            v_off <= '0;
            t_delay <= '0;
            t_on <= '0;
            period <= '0;
            dest <= '0;
            user <= '0;
            tick_div <= '0;
            run <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: begin
                    // A request is decoded once, on the edge that raises the acknowledge
                    if (cfg_req) begin
                        state <= HS_ACKED;
                        case (cfg_addr)
                            ADDR_V_ON: v_on <= cfg_data;
                            ADDR_V_OFF: v_off <= cfg_data;
                            ADDR_T_DELAY: t_delay <= cfg_data;
                            ADDR_T_ON: t_on <= cfg_data;
                            ADDR_PERIOD: period <= cfg_data;
                            // Tags and divider keep only the low bits of the write data
                            ADDR_DEST: dest <= cfg_data[7:0];
                            ADDR_USER: user <= cfg_data[7:0];
                            ADDR_TICK_DIV: tick_div <= cfg_data[15:0];
                            ADDR_CONTROL: run <= cfg_data[0];
                            // Unused addresses still complete the handshake
                            default: ;
                        endcase
                    end
                end
                HS_ACKED: begin
                    // Wait for the host to release the request before going idle again
                    if (!cfg_req) begin
                        state <= HS_IDLE;
                    end
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

endmodule

// File: sample_ticker.sv
// Clock divider that produces one-cycle sample triggers while the generator runs
`timescale 1ns/100ps

module sample_ticker import wavegen_pkg::*; (
    input  logic clock,
    input  logic arst_n,
    input  logic run,
    input  div_t tick_div,
    output logic tick
);

    div_t count;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            tick <= 1'b0;
        end else if (!run) begin
            // Stopped, so the divider is cleared and no trigger goes out
            count <= '0;
            tick <= 1'b0;
        end else if (count == '0) begin
            // Expired count reloads; a divider of zero ticks on every clock
            count <= tick_div;
            tick <= (tick_div == '0);
        end else begin
            // Tick on the step that brings the count down to zero
            count <= count - 1'b1;
            tick <= (count == 16'd1);
        end
    end

endmodule

// File: square_core.sv
// Square-wave core that turns accepted triggers into tagged sample words
`timescale 1ns/100ps

module square_core import wavegen_pkg::*; (
    input  logic   clock,
    input  logic   arst_n,
    input  logic   run,
    input  logic   tick,
    input  word_t  v_on,
    input  word_t  v_off,
    input  phase_t t_delay,
    input  phase_t t_on,
    input  phase_t period,
    input  tag_t   dest,
    input  tag_t   user,
    input  logic   buffer_full,
    output logic   sample_valid,
    output word_t  sample_data,
    output tag_t   sample_dest,
    output tag_t   sample_user,
    output ovf_t   overflow_count
);

    phase_t phase;
    phase_t last_phase;
    word_t level;
    logic accept;

    // Highest phase before the wrap; a zero period behaves like a period of one
    assign last_phase = (period == '0) ? '0 : period - 1'b1;

    // Level belonging to the current phase
    assign level = (phase < t_on) ? v_on : v_off;

    // A trigger only counts when the sender still has room for the sample
    assign accept = run && tick && !buffer_full;

    // Phase counter and refused-trigger counter
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
            overflow_count <= '0;
        end else if (!run) begin
            // Stopped, so the next run starts from the programmed delay
            phase <= t_delay;
        end else if (tick) begin
            if (buffer_full) begin
                // Refused trigger keeps the phase so the waveform has no gap
                if (overflow_count != '1) begin
                    overflow_count <= overflow_count + 1'b1;
                end
            end else if (phase >= last_phase) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Valid flag is a one-cycle pulse after each accepted trigger
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= accept;
        end
    end

    // Sample payload is captured from the phase before it advances
    always_ff @(posedge clock) begin
        if (accept) begin
            sample_data <= level;
            sample_dest <= dest;
            sample_user <= user;
        end
    end

endmodule

// File: sample_sender.sv
// Sample buffer that drains its entries over a four-phase req/ack output port
`timescale 1ns/100ps

module sample_sender import wavegen_pkg::*; (
    input  logic  clock,
    input  logic  arst_n,
    input  logic  sample_valid,
    input  word_t sample_data,
    input  tag_t  sample_dest,
    input  tag_t  sample_user,
    input  logic  out_ack,
    output logic  buffer_full,
    output logic  out_req,
    output word_t out_data,
    output tag_t  out_dest,
    output tag_t  out_user
);

    word_t data_mem [FIFO_DEPTH];
    tag_t dest_mem [FIFO_DEPTH];
    tag_t user_mem [FIFO_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] count;
    sender_state_e state;
    logic pop;

    // Full also covers a sample that is already on its way from the core
    assign buffer_full = (count == FIFO_COUNT_WIDTH'(FIFO_DEPTH))
        || (sample_valid && count == FIFO_COUNT_WIDTH'(FIFO_DEPTH - 1));

    // The head entry stays on the port until the acknowledge pops it
    assign out_data = data_mem[rd_ptr];
    assign out_dest = dest_mem[rd_ptr];
    assign out_user = user_mem[rd_ptr];
    assign out_req = (state == SND_WAIT_ACK_HIGH);
    assign pop = out_req && out_ack;

    always_ff @(posedge clock) begin
        if (sample_valid) begin
            data_mem[wr_ptr] <= sample_data;
            dest_mem[wr_ptr] <= sample_dest;
            user_mem[wr_ptr] <= sample_user;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (sample_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (sample_valid && !pop) count <= count + 1'b1;
            else if (pop && !sample_valid) count <= count - 1'b1;
        end
    end

    // Request rises only with data waiting and the acknowledge already low
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= SND_IDLE;
        end else begin
            case (state)
                SND_IDLE: if (count != '0 && !out_ack) state <= SND_WAIT_ACK_HIGH;
                SND_WAIT_ACK_HIGH: if (out_ack) state <= SND_WAIT_ACK_LOW;
                // After the sink releases the acknowledge the next entry may go straight out
                SND_WAIT_ACK_LOW: if (!out_ack) begin
                    state <= (count != '0) ? SND_WAIT_ACK_HIGH : SND_IDLE;
                end
                default: state <= SND_IDLE;
            endcase
        end
    end

endmodule

// File: wavegen_top.sv
// Square-wave sample generator with req/ack configuration and output ports
`timescale 1ns/100ps

module wavegen_top import wavegen_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      cfg_req,
    input  cfg_addr_t cfg_addr,
    input  word_t     cfg_data,
    input  logic      out_ack,
    output logic      cfg_ack,
    output logic      out_req,
    output word_t     out_data,
    output tag_t      out_dest,
    output tag_t      out_user,
    output ovf_t      overflow_count
);

    // Settings from the register bank
    word_t v_on;
    word_t v_off;
    phase_t t_delay;
    phase_t t_on;
    phase_t period;
    tag_t dest;
    tag_t user;
    div_t tick_div;
    logic run;

    // Trigger, sample path and back-pressure between the blocks
    logic tick;
    logic sample_valid;
    word_t sample_data;
    tag_t sample_dest;
    tag_t sample_user;
    logic buffer_full;

    param_bank i_param_bank (
        .clock(clock), .arst_n(arst_n),
        .cfg_req(cfg_req), .cfg_addr(cfg_addr), .cfg_data(cfg_data), .cfg_ack(cfg_ack),
        .v_on(v_on), .v_off(v_off), .t_delay(t_delay), .t_on(t_on), .period(period),
        .dest(dest), .user(user), .tick_div(tick_div), .run(run)
    );

    sample_ticker i_sample_ticker (
        .clock(clock), .arst_n(arst_n),
        .run(run), .tick_div(tick_div), .tick(tick)
    );

    square_core i_square_core (
        .clock(clock), .arst_n(arst_n), .run(run), .tick(tick),
        .v_on(v_on), .v_off(v_off), .t_delay(t_delay), .t_on(t_on), .period(period),
        .dest(dest), .user(user), .buffer_full(buffer_full),
        .sample_valid(sample_valid), .sample_data(sample_data),
        .sample_dest(sample_dest), .sample_user(sample_user),
        .overflow_count(overflow_count)
    );

    sample_sender i_sample_sender (
        .clock(clock), .arst_n(arst_n),
        .sample_valid(sample_valid), .sample_data(sample_data),
        .sample_dest(sample_dest), .sample_user(sample_user),
        .out_ack(out_ack), .buffer_full(buffer_full), .out_req(out_req),
        .out_data(out_data), .out_dest(out_dest), .out_user(out_user)
    );

endmodule

// File: tb_wavegen.sv
// Directed testbench for the square-wave sample generator with req/ack ports
`timescale 1ns/100ps

module tb_wavegen import wavegen_pkg::*; ();

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    // Longest wait for any handshake edge from the DUT
    localparam int WAIT_LIMIT = 200;
    // Quiet cycles that mark the sample buffer as drained
    localparam int DRAIN_IDLE = 20;
    localparam int MIN_STALL = 20;
    localparam int MAX_STALL = 60;
    // Watchdog budget from test count, samples per test and the worst stall
    localparam int NUM_TESTS = 5;
    localparam int MAX_SAMPLES = 24;
    localparam int SAMPLE_CYCLES = 10;
    localparam int MARGIN_CYCLES = 2000;
    localparam int WATCHDOG_CYCLES =
        NUM_TESTS * MAX_SAMPLES * (MAX_STALL + SAMPLE_CYCLES) + MARGIN_CYCLES;

    logic clock;
    logic arst_n;
    logic cfg_req;
    cfg_addr_t cfg_addr;
    word_t cfg_data;
    logic cfg_ack;
    logic out_ack;
    logic out_req;
    word_t out_data;
    tag_t out_dest;
    tag_t out_user;
    ovf_t overflow_count;

    integer seed;
    int error_count;
    int tests_passed;
    int tests_failed;
    string test_name;

    wavegen_top i_wavegen_top (
        .clock(clock), .arst_n(arst_n),
        .cfg_req(cfg_req), .cfg_addr(cfg_addr), .cfg_data(cfg_data), .out_ack(out_ack),
        .cfg_ack(cfg_ack), .out_req(out_req), .out_data(out_data),
        .out_dest(out_dest), .out_user(out_user), .overflow_count(overflow_count)
    );

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Ends a run that stopped making progress
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d clock cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // Level of sample k after a run start, straight from the sample rule
    function automatic word_t expected_level(int k, phase_t delay, phase_t on_time,
                                             phase_t per, word_t lvl_on, word_t lvl_off);
        longint unsigned span;
        longint unsigned phase;
        // A zero period behaves like a period of one
        span = (per == '0) ? 1 : per;
        phase = (longint'(delay) + k) % span;
        return (phase < on_time) ? lvl_on : lvl_off;
    endfunction

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // All stimulus changes 1 ns after the rising edge
    task automatic wait_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic write_cfg(cfg_addr_t addr, word_t data);
        int waited;
        waited = 0;
        cfg_addr = addr;
        cfg_data = data;
        cfg_req = 1'b1;
        while (!cfg_ack && waited < WAIT_LIMIT) begin
            wait_cycle();
            waited++;
        end
        cfg_req = 1'b0;
        if (!cfg_ack) begin
            $display("Configuration write to address %0d was never acknowledged", addr);
            error_count++;
            return;
        end
        waited = 0;
        while (cfg_ack && waited < WAIT_LIMIT) begin
            wait_cycle();
            waited++;
        end
        if (cfg_ack) begin
            $display("cfg_ack stayed high after the request was released");
            error_count++;
        end
    endtask

    // Sink side of the output handshake with an optional stall before the acknowledge
    task automatic receive_sample(output word_t data, output tag_t d, output tag_t u,
                                  output bit ok, input int stall);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!out_req && waited < WAIT_LIMIT) begin
            wait_cycle();
            waited++;
        end
        if (!out_req) begin
            $display("No output request arrived in %s within %0d cycles", test_name, WAIT_LIMIT);
            error_count++;
            return;
        end
        data = out_data;
        d = out_dest;
        u = out_user;
        repeat (stall) wait_cycle();
        out_ack = 1'b1;
        waited = 0;
        while (out_req && waited < WAIT_LIMIT) begin
            wait_cycle();
            waited++;
        end
        out_ack = 1'b0;
        if (out_req) begin
            $display("out_req stayed high after out_ack was raised in %s", test_name);
            error_count++;
            return;
        end
        ok = 1'b1;
    endtask

    // Receives a run of samples and checks each against the sample rule
    task automatic check_stream(int count, phase_t delay, phase_t on_time, phase_t per,
                                word_t lvl_on, word_t lvl_off, tag_t exp_dest,
                                tag_t exp_user, bit stall_some);
        word_t data;
        tag_t d;
        tag_t u;
        bit ok;
        int stall;
        int k;
        int unsigned draw;
        for (k = 0; k < count; k++) begin
            stall = 0;
            if (stall_some) begin
                draw = $random(seed);
                // Roughly one acknowledge in four is held back
                if (draw[1:0] == 2'b00)
                    stall = MIN_STALL + (draw[31:8] % (MAX_STALL - MIN_STALL + 1));
            end
            receive_sample(data, d, u, ok, stall);
            if (!ok) return;
            check_value($sformatf("sample %0d level", k),
                        expected_level(k, delay, on_time, per, lvl_on, lvl_off), data);
            check_value($sformatf("sample %0d dest", k), exp_dest, d);
            check_value($sformatf("sample %0d user", k), exp_user, u);
        end
    endtask

    // Acknowledges whatever is left until the port stays quiet
    task automatic stop_and_drain();
        word_t data;
        tag_t d;
        tag_t u;
        bit ok;
        int idle;
        write_cfg(ADDR_CONTROL, 32'd0);
        idle = 0;
        while (idle < DRAIN_IDLE) begin
            if (out_req) begin
                receive_sample(data, d, u, ok, 0);
                idle = 0;
            end else begin
                wait_cycle();
                idle++;
            end
        end
    endtask

    task automatic expect_no_request(int cycles);
        repeat (cycles) begin
            wait_cycle();
            if (out_req) begin
                $display("Unexpected output request in %s while the generator is stopped",
                         test_name);
                error_count++;
                return;
            end
        end
    endtask

    task automatic report_test(int start_errors);
        if (error_count == start_errors) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", test_name, error_count - start_errors);
            tests_failed++;
        end
    endtask

    task automatic test_reset_state();
        int start_errors;
        start_errors = error_count;
        test_name = "reset_state";
        check_value("cfg_ack", 0, cfg_ack);
        check_value("out_req", 0, out_req);
        check_value("overflow_count", 0, overflow_count);
        expect_no_request(50);
        report_test(start_errors);
    endtask

    task automatic test_basic_wave();
        int start_errors;
        start_errors = error_count;
        test_name = "basic_wave";
        write_cfg(ADDR_V_ON, 32'hA5A5_0001);
        write_cfg(ADDR_V_OFF, 32'h0000_0F0F);
        write_cfg(ADDR_T_DELAY, 32'd0);
        write_cfg(ADDR_T_ON, 32'd3);
        write_cfg(ADDR_PERIOD, 32'd8);
        write_cfg(ADDR_DEST, 32'd12);
        write_cfg(ADDR_USER, 32'd34);
        write_cfg(ADDR_TICK_DIV, 32'd2);
        write_cfg(ADDR_CONTROL, 32'd1);
        check_stream(16, 0, 3, 8, 32'hA5A5_0001, 32'h0000_0F0F, 8'd12, 8'd34, 1'b0);
        report_test(start_errors);
    endtask

    task automatic test_delay_wrap();
        int start_errors;
        start_errors = error_count;
        test_name = "delay_wrap";
        stop_and_drain();
        write_cfg(ADDR_T_DELAY, 32'd6);
        write_cfg(ADDR_PERIOD, 32'd7);
        write_cfg(ADDR_T_ON, 32'd2);
        write_cfg(ADDR_V_ON, 32'h1234_5678);
        write_cfg(ADDR_V_OFF, 32'h0000_00C3);
        write_cfg(ADDR_CONTROL, 32'd1);
        check_stream(14, 6, 2, 7, 32'h1234_5678, 32'h0000_00C3, 8'd12, 8'd34, 1'b0);
        report_test(start_errors);
    endtask

    task automatic test_back_pressure();
        int start_errors;
        ovf_t start_overflow;
        start_errors = error_count;
        test_name = "back_pressure";
        stop_and_drain();
        start_overflow = overflow_count;
        // A trigger on every clock outruns the sink and fills the buffer
        write_cfg(ADDR_TICK_DIV, 32'd0);
        write_cfg(ADDR_CONTROL, 32'd1);
        check_stream(24, 6, 2, 7, 32'h1234_5678, 32'h0000_00C3, 8'd12, 8'd34, 1'b1);
        check_value("overflow_count increased", 1, overflow_count > start_overflow);
        report_test(start_errors);
    endtask

    task automatic test_stop_restart();
        int start_errors;
        start_errors = error_count;
        test_name = "stop_restart";
        stop_and_drain();
        expect_no_request(30);
        // Moving the delay puts the restart phase away from where the last run stopped
        write_cfg(ADDR_T_DELAY, 32'd3);
        write_cfg(ADDR_V_ON, 32'hDEAD_0005);
        write_cfg(ADDR_DEST, 32'h5A);
        write_cfg(ADDR_USER, 32'h77);
        write_cfg(ADDR_CONTROL, 32'd1);
        check_stream(10, 3, 2, 7, 32'hDEAD_0005, 32'h0000_00C3, 8'h5A, 8'h77, 1'b0);
        report_test(start_errors);
    endtask

    initial begin
        seed = 32'h8fc8;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name = "none";
        arst_n = 1'b0;
        cfg_req = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        out_ack = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        arst_n = 1'b1;
        test_reset_state();
        test_basic_wave();
        test_delay_wrap();
        test_back_pressure();
        test_stop_restart();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
wavegen_pkg.sv
param_bank.sv
sample_ticker.sv
square_core.sv
sample_sender.sv
wavegen_top.sv
tb_wavegen.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the square-wave generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_wavegen -o tb_wavegen_sim
./obj_dir/tb_wavegen_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
